//--- Makefile
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f wb_xbar.f --top-module tb_wb_xbar

sim:
	verilator --binary --timing -f wb_xbar.f --top-module tb_wb_xbar -o sim_tb
	./obj_dir/sim_tb 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@grep -q "Testbench passed" $(LOG) || { echo "Simulation ended early"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- hdl/rr_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_xbar_defs.svh"

module rr_arbiter
	import xbar_pkg::*;
#(
	parameter int N_REQ = `XBAR_N_MASTERS
) (
	input  wire logic             clk,
	input  wire logic             rstn,
	input  wire logic [N_REQ-1:0] req_i,
	output logic                  gnt_o,
	output master_id_t            gnt_id_o
);

	master_id_t pick_id;
	logic       pick_vld;
	int         idx;

	// Scan from the last grant upward and wrap, the nearest requester wins
	// k == N_REQ lands back on the last owner, so it has lowest priority
	always_comb begin
		pick_vld = 1'b0;
		pick_id = gnt_id_o;
		idx = 0;
		for (int k = N_REQ; k >= 1; k--) begin
			idx = (int'(gnt_id_o) + k) % N_REQ;
			if (req_i[idx]) begin
				pick_vld = 1'b1;
				pick_id = master_id_t'(idx);
			end
		end
	end

	// gnt_id_o doubles as the round-robin pointer once released
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= 1'b0;
			gnt_id_o <= '0;
		end else if (!gnt_o) begin
			if (pick_vld) begin
				gnt_o <= 1'b1;
				gnt_id_o <= pick_id;
			end
		end else if (!req_i[gnt_id_o]) begin
			// Owner let go
			gnt_o <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/wb_interconnect.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_xbar_defs.svh"

module wb_interconnect
	import wb_pkg::*;
	import xbar_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rstn,
	input  wire wb_req_t m_req_i [`XBAR_N_MASTERS],
	output wb_rsp_t      m_rsp_o [`XBAR_N_MASTERS],
	output wb_req_t      s_req_o [2],
	input  wire wb_rsp_t s_rsp_i [2]
);

	localparam int N_M = `XBAR_N_MASTERS;
	// Two SRAMs plus the decode-error target
	localparam int N_T = 3;

	// Per-master transfer state
	logic    m_busy_q [N_M];
	target_t m_tgt_q  [N_M];

	// Per-target arbitration and muxed bus
	logic [N_M-1:0] t_req_vec [N_T];
	logic           t_gnt     [N_T];
	master_id_t     t_gnt_id  [N_T];
	wb_req_t        t_req     [N_T];
	wb_rsp_t        t_rsp     [N_T];

	logic derr_q;

	// Master goes busy on a new strobe and idle on its ack or err
	for (genvar m = 0; m < N_M; m++) begin : g_mst
		always_ff @(posedge clk) begin
			if (!rstn) begin
				m_busy_q[m] <= 1'b0;
				m_tgt_q[m] <= TGT_NONE;
			end else if (!m_busy_q[m]) begin
				if (m_req_i[m].cyc && m_req_i[m].stb) begin
					m_busy_q[m] <= 1'b1;
					m_tgt_q[m] <= decode_target(m_req_i[m].adr);
				end
			end else if (m_rsp_o[m].ack || m_rsp_o[m].err) begin
				m_busy_q[m] <= 1'b0;
				m_tgt_q[m] <= TGT_NONE;
			end
		end
	end

	// Request vector seen by each target's arbiter
	always_comb begin
		for (int t = 0; t < N_T; t++) begin
			t_req_vec[t] = '0;
			for (int m = 0; m < N_M; m++) begin
				t_req_vec[t][m] = m_busy_q[m] && (m_tgt_q[m] == target_t'(t));
			end
		end
	end

	for (genvar t = 0; t < N_T; t++) begin : g_arb
		rr_arbiter #(
			.N_REQ (N_M)
		) u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (t_req_vec[t]),
			.gnt_o    (t_gnt[t]),
			.gnt_id_o (t_gnt_id[t])
		);
	end

	// Forward only while the owner is still busy on this target,
	// so the release cycle after ack never leaks a new strobe through
	always_comb begin
		for (int t = 0; t < N_T; t++) begin
			t_req[t] = '0;
			if (t_gnt[t] && t_req_vec[t][t_gnt_id[t]]) begin
				t_req[t] = m_req_i[t_gnt_id[t]];
			end
		end
	end

	// Response back to the owning master, zero for everyone else
	always_comb begin
		for (int m = 0; m < N_M; m++) begin
			m_rsp_o[m] = '0;
			for (int t = 0; t < N_T; t++) begin
				if (t_req_vec[t][m] && t_gnt[t] && t_gnt_id[t] == master_id_t'(m)) begin
					m_rsp_o[m] = t_rsp[t];
				end
			end
		end
	end

	assign s_req_o[0] = t_req[TGT_SLV0];
	assign s_req_o[1] = t_req[TGT_SLV1];
	assign t_rsp[TGT_SLV0] = s_rsp_i[0];
	assign t_rsp[TGT_SLV1] = s_rsp_i[1];

	// Decode-error target, err one cycle after each new strobe
	always_ff @(posedge clk) begin
		if (!rstn) begin
			derr_q <= 1'b0;
		end else begin
			derr_q <= t_req[TGT_DERR].cyc && t_req[TGT_DERR].stb && !derr_q;
		end
	end

	assign t_rsp[TGT_DERR] = '{ack: 1'b0, err: derr_q, dat: '0};

endmodule

`default_nettype wire

//--- hdl/wb_pkg.sv
`default_nettype none

`include "wb_xbar_defs.svh"

package wb_pkg;

	// Master to slave, classic single transfers only
	typedef struct packed {
		logic                  cyc;
		logic                  stb;
		logic                  we;
		logic [`WB_ADDR_W-1:0] adr;
		logic [`WB_SEL_W-1:0]  sel;
		logic [`WB_DATA_W-1:0] dat;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		logic                  ack;
		logic                  err;
		logic [`WB_DATA_W-1:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

//--- hdl/wb_sram.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_xbar_defs.svh"

module wb_sram
	import wb_pkg::*;
#(
	parameter int WORDS = `SRAM0_WORDS
) (
	input  wire logic    clk,
	input  wire logic    rstn,
	input  wire wb_req_t req_i,
	output wb_rsp_t      rsp_o
);

	localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

	logic [`WB_DATA_W-1:0] mem [WORDS];
	logic [`WB_DATA_W-1:0] rdat_q;
	logic [IDX_W-1:0]      idx;
	logic                  ack_q;
	logic                  hit;

	// A strobe counts once, the ack cycle itself is not a new access
	assign hit = req_i.cyc && req_i.stb && !ack_q;
	assign idx = IDX_W'(req_i.adr[`WB_ADDR_W-1:2] % WORDS);

	always_ff @(posedge clk) begin
		if (hit && req_i.we) begin
			for (int b = 0; b < `WB_SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
				end
			end
		end
		if (hit && !req_i.we) begin
			rdat_q <= mem[idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= hit;
		end
	end

	assign rsp_o = '{ack: ack_q, err: 1'b0, dat: rdat_q};

endmodule

`default_nettype wire

//--- hdl/wb_xbar_defs.svh
`ifndef WB_XBAR_DEFS_SVH
`define WB_XBAR_DEFS_SVH

// Bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32
`define WB_SEL_W 4

// Crossbar size
`define XBAR_N_MASTERS 4

// SRAM depths in words
`define SRAM0_WORDS 256
`define SRAM1_WORDS 128

// Address map, limits are inclusive
`define SLV0_BASE 32'h0000_0000
`define SLV0_LIMIT 32'h0000_03FF
`define SLV1_BASE 32'h1000_0000
`define SLV1_LIMIT 32'h1000_01FF

`endif

//--- hdl/wb_xbar_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_xbar_defs.svh"

module wb_xbar_top
	import wb_pkg::*;
(
	input  wire logic    clk,
	input  wire logic    rstn,
	input  wire wb_req_t m_req_i [`XBAR_N_MASTERS],
	output wb_rsp_t      m_rsp_o [`XBAR_N_MASTERS]
);

	wb_req_t s_req [2];
	wb_rsp_t s_rsp [2];

	wb_interconnect u_ic (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req_i),
		.m_rsp_o (m_rsp_o),
		.s_req_o (s_req),
		.s_rsp_i (s_rsp)
	);

	// Slave 0 at SLV0_BASE
	wb_sram #(
		.WORDS (`SRAM0_WORDS)
	) u_sram0 (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s_req[0]),
		.rsp_o (s_rsp[0])
	);

	// Slave 1 at SLV1_BASE
	wb_sram #(
		.WORDS (`SRAM1_WORDS)
	) u_sram1 (
		.clk   (clk),
		.rstn  (rstn),
		.req_i (s_req[1]),
		.rsp_o (s_rsp[1])
	);

endmodule

`default_nettype wire

//--- hdl/xbar_pkg.sv
`default_nettype none

`include "wb_xbar_defs.svh"

package xbar_pkg;

	typedef logic [$clog2(`XBAR_N_MASTERS)-1:0] master_id_t;

	// TGT_NONE marks a master with nothing in flight
	typedef enum logic [1:0] {
		TGT_SLV0 = 2'd0,
		TGT_SLV1 = 2'd1,
		TGT_DERR = 2'd2,
		TGT_NONE = 2'd3
	} target_t;

	// Lower ranges win on overlap
	function automatic target_t decode_target(input logic [`WB_ADDR_W-1:0] adr);
		if (adr >= `SLV0_BASE && adr <= `SLV0_LIMIT) begin
			return TGT_SLV0;
		end
		if (adr >= `SLV1_BASE && adr <= `SLV1_LIMIT) begin
			return TGT_SLV1;
		end
		return TGT_DERR;
	endfunction

endpackage

`default_nettype wire

//--- verif/tb_wb_xbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "wb_xbar_defs.svh"

module tb_wb_xbar
	import wb_pkg::*;
	import xbar_pkg::*;
();

	localparam int MODE_QUARTER = 0;
	localparam int MODE_SLV0 = 1;
	localparam int MODE_SLV1 = 2;
	localparam int MODE_BOTH = 3;
	localparam int N_FILL = `SRAM0_WORDS + `SRAM1_WORDS;
	localparam int N_RAND = 24;
	localparam int N_DERR = 5;
	localparam int N_CONC = 30;
	localparam int N_FAIR = 12;
	localparam int N_PAR = 20;
	localparam int N_PLANNED = N_FILL + 2 * N_RAND + N_DERR + 4 * N_CONC + 4 * N_FAIR + 2 * N_PAR;
	localparam int TIMEOUT_NS = N_PLANNED * 20 * `XBAR_N_MASTERS * 8;

	// One completed transfer as seen by its master
	typedef struct packed {
		master_id_t            mst;
		logic                  we;
		logic [`WB_ADDR_W-1:0] adr;
		logic [`WB_SEL_W-1:0]  sel;
		logic [`WB_DATA_W-1:0] wdat;
		wb_rsp_t               rsp;
	} xfer_rec_t;

	logic                  clk;
	logic                  rstn;
	wb_req_t               m_req [`XBAR_N_MASTERS];
	wb_rsp_t               m_rsp [`XBAR_N_MASTERS];
	logic [`WB_DATA_W-1:0] shadow0 [`SRAM0_WORDS];
	logic [`WB_DATA_W-1:0] shadow1 [`SRAM1_WORDS];
	logic [31:0]           rng_st [`XBAR_N_MASTERS];
	xfer_rec_t             rec_q [$];
	int                    cmpl_log [$];
	logic                  fair_on;
	int                    n_checked;

	wb_xbar_top i_dut (
		.clk     (clk),
		.rstn    (rstn),
		.m_req_i (m_req),
		.m_rsp_o (m_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
			$display("Testbench failed");
			$fatal(1);
		end
	endtask

	// Separate stream per master keeps parallel drivers reproducible
	function automatic logic [31:0] next_rand(input int m);
		rng_st[m] = rng_st[m] * 32'd1664525 + 32'd1013904223;
		return {rng_st[m][15:0], rng_st[m][31:16]};
	endfunction

	function automatic logic [31:0] pick_adr(input int m, input int mode, input logic [31:0] r);
		case (mode)
			MODE_QUARTER: return `SLV0_BASE + m * `SRAM0_WORDS + (r % (`SRAM0_WORDS / 4)) * 4;
			MODE_SLV1: return `SLV1_BASE + (r % `SRAM1_WORDS) * 4;
			MODE_BOTH: return r[16] ? `SLV1_BASE + (r % `SRAM1_WORDS) * 4
				: `SLV0_BASE + (r % `SRAM0_WORDS) * 4;
			default: return `SLV0_BASE + (r % `SRAM0_WORDS) * 4;
		endcase
	endfunction

	// Shadow memory model where writes merge by byte lane
	function automatic void ref_access(input logic we, input logic [31:0] adr,
			input logic [3:0] sel, input logic [31:0] wdat,
			output logic [31:0] rdat, output logic err);
		target_t     tgt;
		int          idx;
		logic [31:0] word;
		tgt = decode_target(adr);
		err = (tgt == TGT_DERR);
		rdat = '0;
		if (err) begin
			return;
		end
		if (tgt == TGT_SLV0) begin
			idx = int'(adr[31:2]) % `SRAM0_WORDS;
			word = shadow0[idx];
		end else begin
			idx = int'(adr[31:2]) % `SRAM1_WORDS;
			word = shadow1[idx];
		end
		if (!we) begin
			rdat = word;
			return;
		end
		for (int b = 0; b < `WB_SEL_W; b++) begin
			if (sel[b]) begin
				word[8*b +: 8] = wdat[8*b +: 8];
			end
		end
		if (tgt == TGT_SLV0) begin
			shadow0[idx] = word;
		end else begin
			shadow1[idx] = word;
		end
	endfunction

	// Single transfer with the response sampled mid-cycle
	task automatic xfer(input int m, input logic we, input logic [31:0] adr,
			input logic [3:0] sel, input logic [31:0] dat, input logic chk_lat);
		xfer_rec_t rec;
		int        lat;
		@(posedge clk);
		m_req[m] <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
		lat = 0;
		@(negedge clk);
		while (!(m_rsp[m].ack || m_rsp[m].err)) begin
			lat++;
			@(negedge clk);
		end
		rec = '{mst: master_id_t'(m), we: we, adr: adr, sel: sel, wdat: dat, rsp: m_rsp[m]};
		rec_q.push_back(rec);
		if (fair_on) begin
			cmpl_log.push_back(m);
		end
		@(posedge clk);
		m_req[m] <= '0;
		// Strobe to response is three cycles on a free target
		if (chk_lat) begin
			check_val($sformatf("latency of master %0d", m), lat, 3);
		end
	endtask

	task automatic run_master(input int m, input int n, input int mode, input logic chk_lat);
		logic [31:0] r;
		for (int i = 0; i < n; i++) begin
			r = next_rand(m);
			xfer(m, r[8], pick_adr(m, mode, r), r[15:12], next_rand(m), chk_lat);
		end
	endtask

	// Between two completions of a master each other master completes once
	task automatic check_fairness();
		int seen [`XBAR_N_MASTERS];
		int prev;
		for (int p = 0; p < cmpl_log.size(); p++) begin
			prev = -1;
			for (int k = p - 1; k >= 0 && prev < 0; k--) begin
				if (cmpl_log[k] == cmpl_log[p]) begin
					prev = k;
				end
			end
			if (prev >= 0) begin
				foreach (seen[i]) begin
					seen[i] = 0;
				end
				for (int k = prev + 1; k < p; k++) begin
					seen[cmpl_log[k]]++;
				end
				foreach (seen[i]) begin
					if (i != cmpl_log[p]) begin
						check_val($sformatf("completions of master %0d in window of master %0d",
							i, cmpl_log[p]), seen[i], 1);
					end
				end
			end
		end
	endtask

	// Checker draining the completed transfers once per cycle
	initial begin
		xfer_rec_t   rec;
		logic [31:0] exp_dat;
		logic        exp_err;
		forever begin
			@(posedge clk);
			while (rec_q.size() > 0) begin
				rec = rec_q.pop_front();
				ref_access(rec.we, rec.adr, rec.sel, rec.wdat, exp_dat, exp_err);
				check_val($sformatf("m_rsp_o[%0d].ack", rec.mst), 32'(rec.rsp.ack), 32'(!exp_err));
				check_val($sformatf("m_rsp_o[%0d].err", rec.mst), 32'(rec.rsp.err), 32'(exp_err));
				if (!rec.we) begin
					check_val($sformatf("m_rsp_o[%0d].dat", rec.mst), rec.rsp.dat, exp_dat);
				end
				n_checked++;
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout after %0d ns, the transfers did not complete", TIMEOUT_NS);
		$display("Testbench failed");
		$fatal(1);
	end

	initial begin
		logic [31:0] seed;
		logic [31:0] r;
		logic [31:0] adr;
		logic [31:0] wr_adr [$];
		rstn = 1'b0;
		fair_on = 1'b0;
		n_checked = 0;
		for (int m = 0; m < `XBAR_N_MASTERS; m++) begin
			m_req[m] = '0;
		end
		seed = 32'd15;
		for (int m = 0; m < `XBAR_N_MASTERS; m++) begin
			seed = seed * 32'd1664525 + 32'd1013904223;
			rng_st[m] = seed;
		end
		repeat (10) @(posedge clk);
		rstn <= 1'b1;

		// Quiet bus right after reset
		repeat (4) begin
			@(negedge clk);
			for (int m = 0; m < `XBAR_N_MASTERS; m++) begin
				check_val($sformatf("m_rsp_o[%0d].ack", m), 32'(m_rsp[m].ack), 32'h0);
				check_val($sformatf("m_rsp_o[%0d].err", m), 32'(m_rsp[m].err), 32'h0);
			end
		end

		// Full-word fill, then partial lane writes and read back
		for (int i = 0; i < `SRAM0_WORDS; i++) begin
			xfer(0, 1'b1, `SLV0_BASE + i * 4, 4'hf, next_rand(0), 1'b0);
		end
		for (int i = 0; i < `SRAM1_WORDS; i++) begin
			xfer(0, 1'b1, `SLV1_BASE + i * 4, 4'hf, next_rand(0), 1'b0);
		end
		for (int i = 0; i < N_RAND; i++) begin
			r = next_rand(0);
			adr = pick_adr(0, MODE_BOTH, r);
			wr_adr.push_back(adr);
			xfer(0, 1'b1, adr, r[15:12], next_rand(0), 1'b0);
		end
		foreach (wr_adr[i]) begin
			xfer(0, 1'b0, wr_adr[i], 4'h0, 32'h0, 1'b0);
		end

		// Unmapped addresses alias word 0 of both SRAMs if they leaked
		xfer(0, 1'b1, 32'h2000_0000, 4'hf, 32'hdead_beef, 1'b0);
		xfer(0, 1'b0, 32'h2000_0000, 4'hf, 32'h0, 1'b0);
		xfer(0, 1'b1, 32'h0000_0400, 4'hf, 32'hcafe_f00d, 1'b0);
		xfer(0, 1'b0, `SLV0_BASE, 4'hf, 32'h0, 1'b0);
		xfer(0, 1'b0, `SLV1_BASE, 4'hf, 32'h0, 1'b0);

		fork
			run_master(0, N_CONC, MODE_QUARTER, 1'b0);
			run_master(1, N_CONC, MODE_QUARTER, 1'b0);
			run_master(2, N_CONC, MODE_QUARTER, 1'b0);
			run_master(3, N_CONC, MODE_QUARTER, 1'b0);
		join

		fair_on = 1'b1;
		fork
			run_master(0, N_FAIR, MODE_QUARTER, 1'b0);
			run_master(1, N_FAIR, MODE_QUARTER, 1'b0);
			run_master(2, N_FAIR, MODE_QUARTER, 1'b0);
			run_master(3, N_FAIR, MODE_QUARTER, 1'b0);
		join
		fair_on = 1'b0;
		check_fairness();

		// Different targets run side by side without waiting
		fork
			run_master(0, N_PAR, MODE_SLV0, 1'b1);
			run_master(1, N_PAR, MODE_SLV1, 1'b1);
		join

		repeat (2) @(posedge clk);
		if (n_checked == N_PLANNED) begin
			$display("Testbench passed");
			$finish;
		end else begin
			$display("Only %0d of %0d transfers were checked", n_checked, N_PLANNED);
			$display("Testbench failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- wb_xbar.f
+incdir+hdl
hdl/wb_pkg.sv
hdl/xbar_pkg.sv
hdl/rr_arbiter.sv
hdl/wb_sram.sv
hdl/wb_interconnect.sv
hdl/wb_xbar_top.sv
verif/tb_wb_xbar.sv
